/* rtl/lockPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Lock unit package
// Shared widths, ID types and the
// command opcodes of the lock unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package lockPkg;

    // Number of mutual-exclusion locks in the table
    localparam int numLocks = 8;

    // Bits needed to index one lock
    localparam int lockIdWidth = 3;

    // Width of the command and reply streams
    localparam int dataWidth = 64;

    // Accelerator ID, TID on the way in and TDEST on the way out
    typedef logic [3:0] accIdT;

    // Index into the lock table
    typedef logic [lockIdWidth-1:0] lockIdT;

    // Opcodes found in the low byte of a command message
    typedef enum logic [7:0] {
        // Unknown code, the message is consumed with no effect
        lockOpNone   = 8'h00,
        lockOpLock   = 8'h04,
        lockOpUnlock = 8'h06
    } lockOpT;

endpackage

`default_nettype wire

/* rtl/lockReqIf.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Lock request channel
// Decoded commands travelling from
// the decoder to the lock table
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

interface lockReqIf import lockPkg::*; ();

    logic   valid;
    logic   ready;
    lockOpT op;
    lockIdT lockId;
    accIdT  sender;

    // Decoder side
    modport source (
        output valid,
        output op,
        output lockId,
        output sender,
        input  ready
    );

    // Lock table side
    modport sink (
        input  valid,
        input  op,
        input  lockId,
        input  sender,
        output ready
    );

endinterface

`default_nettype wire

/* rtl/lockAckIf.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Lock acknowledgement channel
// Grant or deny replies from the
// lock table to the output side
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

interface lockAckIf import lockPkg::*; ();

    logic  valid;
    logic  ready;
    logic  granted;
    accIdT dest;

    // Lock table side
    modport source (
        output valid,
        output granted,
        output dest,
        input  ready
    );

    // Reply sender side
    modport sink (
        input  valid,
        input  granted,
        input  dest,
        output ready
    );

endinterface

`default_nettype wire

/* rtl/lockCmdDecoder.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Lock command decoder
// Accepts one-beat command messages,
// decodes opcode and lock ID and
// holds one pending request
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module lockCmdDecoder import lockPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [dataWidth-1:0] inData,
    input  logic                 inValid,
    input  accIdT                inId,
    output logic                 inReady,
    lockReqIf.source             req
);

    logic   reqValid;
    lockOpT reqOp;
    lockIdT reqLockId;
    accIdT  reqSender;
    logic   accept;
    lockOpT decodedOp;

    // Room when empty or when the held request leaves on this edge
    assign inReady = !reqValid || req.ready;
    assign accept  = inValid && inReady;

    // Anything other than lock or unlock is marked for dropping
    always_comb begin
        case (inData[7:0])
            lockOpLock:   decodedOp = lockOpLock;
            lockOpUnlock: decodedOp = lockOpUnlock;
            default:      decodedOp = lockOpNone;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            reqValid <= 1'b0;
        end else if (accept) begin
            reqValid <= 1'b1;
        end else if (req.ready) begin
            reqValid <= 1'b0;
        end
    end

    // Payload only loads on acceptance, so it holds while stalled
    always_ff @(posedge clk) begin
        if (accept) begin
            reqOp     <= decodedOp;
            reqLockId <= inData[8 +: lockIdWidth];
            reqSender <= inId;
        end
    end

    assign req.valid  = reqValid;
    assign req.op     = reqOp;
    assign req.lockId = reqLockId;
    assign req.sender = reqSender;

    // A stalled request keeps its contents until the table takes it
    assert property (@(posedge clk) disable iff (!rstN)
        req.valid && !req.ready |=>
            req.valid && $stable({req.op, req.lockId, req.sender}))
        else $error("lock request changed while stalled");

endmodule

`default_nettype wire

/* rtl/lockTable.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Lock table
// Keeps one held bit per lock,
// grants free locks, releases on
// unlock and answers lock requests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module lockTable import lockPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    lockReqIf.sink    req,
    lockAckIf.source  ack
);

    logic [numLocks-1:0] held;
    logic                isLock;
    logic                isUnlock;
    logic                reqFire;

    assign isLock   = (req.op == lockOpLock);
    assign isUnlock = (req.op == lockOpUnlock);

    // Only a lock request needs a reply slot and everything else drains at once
    assign req.ready = isLock ? ack.ready : 1'b1;
    assign reqFire   = req.valid && req.ready;

    // Reply is formed straight from the pending request
    assign ack.valid   = req.valid && isLock;
    assign ack.granted = !held[req.lockId];
    assign ack.dest    = req.sender;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            held <= '0;
        end else if (reqFire) begin
            // Any sender may release any lock since ownership is not tracked
            if (isLock) begin
                held[req.lockId] <= 1'b1;
            end else if (isUnlock) begin
                held[req.lockId] <= 1'b0;
            end
        end
    end

    // Replies only come from lock requests, never from unlock or dropped ones
    assert property (@(posedge clk) disable iff (!rstN)
        req.valid && !isLock |-> !ack.valid)
        else $error("ack raised for a non-lock request");

endmodule

`default_nettype wire

/* rtl/lockAckSender.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Lock acknowledgement sender
// One-entry output register that
// drives replies onto the stream
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module lockAckSender import lockPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    lockAckIf.sink               ack,
    output logic [dataWidth-1:0] outData,
    output logic                 outValid,
    output accIdT                outDest,
    input  logic                 outReady
);

    logic grantedQ;
    logic capture;

    // Free slot or the current beat leaves on this edge
    assign ack.ready = !outValid || outReady;
    assign capture   = ack.valid && ack.ready;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (capture) begin
            outValid <= 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            grantedQ <= ack.granted;
            outDest  <= ack.dest;
        end
    end

    // Data word is 1 for granted, 0 for denied
    assign outData = {{(dataWidth-1){1'b0}}, grantedQ};

    // Reply beat is frozen while the consumer stalls
    assert property (@(posedge clk) disable iff (!rstN)
        outValid && !outReady |=>
            outValid && $stable(outData) && $stable(outDest))
        else $error("reply changed while outReady low");

endmodule

`default_nettype wire

/* rtl/lockUnit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Hardware lock unit
// Command stream in, grant/deny
// replies out, eight locks inside
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module lockUnit import lockPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    // Command stream
    input  logic [dataWidth-1:0] inData,
    input  logic                 inValid,
    input  accIdT                inId,
    output logic                 inReady,
    // Reply stream
    output logic [dataWidth-1:0] outData,
    output logic                 outValid,
    input  logic                 outReady,
    output accIdT                outDest
);

    lockReqIf reqIf ();
    lockAckIf ackIf ();

    lockCmdDecoder i_lockCmdDecoder (
        .clk     (clk),
        .rstN    (rstN),
        .inData  (inData),
        .inValid (inValid),
        .inId    (inId),
        .inReady (inReady),
        .req     (reqIf.source)
    );

    lockTable i_lockTable (
        .clk  (clk),
        .rstN (rstN),
        .req  (reqIf.sink),
        .ack  (ackIf.source)
    );

    lockAckSender i_lockAckSender (
        .clk      (clk),
        .rstN     (rstN),
        .ack      (ackIf.sink),
        .outData  (outData),
        .outValid (outValid),
        .outDest  (outDest),
        .outReady (outReady)
    );

endmodule

`default_nettype wire

/* testbench/lockUnitTb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Lock unit testbench
// Random commands against a lock-state
// model, random back-pressure on replies
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module lockUnitTb import lockPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int numMsgs     = 400;
    localparam int maxCycles   = numMsgs * 40;
    localparam int drainCycles = 20;

    logic                 clk;
    logic                 rstN;
    logic [dataWidth-1:0] inData;
    logic                 inValid;
    accIdT                inId;
    logic                 inReady;
    logic [dataWidth-1:0] outData;
    logic                 outValid;
    logic                 outReady;
    accIdT                outDest;

    // Reference model, lock states and replies still owed
    logic [numLocks-1:0]  modelHeld;
    logic [dataWidth-1:0] expData[$];
    accIdT                expDest[$];

    // DUT outputs as seen mid-cycle
    logic                 inReadyS;
    logic                 outValidS;
    logic [dataWidth-1:0] outDataS;
    accIdT                outDestS;
    logic                 stalledBeat;

    int sent;
    int stallLeft;
    int drained;
    int cycleCount;
    int valueErrors;
    int protoErrors;
    int repliesChecked;
    int grantsSeen;

    lockUnit i_lockUnit (
        .clk      (clk),
        .rstN     (rstN),
        .inData   (inData),
        .inValid  (inValid),
        .inId     (inId),
        .inReady  (inReady),
        .outData  (outData),
        .outValid (outValid),
        .outReady (outReady),
        .outDest  (outDest)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic checkDest(input accIdT got, input accIdT expected);
        if (got !== expected) begin
            $display("Fail outDest at %0t: got 0x%h, expected 0x%h", $time, got, expected);
            valueErrors++;
        end
    endtask

    task automatic checkGrant(input logic [dataWidth-1:0] got,
                              input logic [dataWidth-1:0] expected);
        if (got !== expected) begin
            $display("Fail outData at %0t: got 0x%h, expected 0x%h", $time, got, expected);
            valueErrors++;
        end
    endtask

    // Random message, mostly lock and unlock, random lock ID and upper bits
    function automatic logic [dataWidth-1:0] makeMessage();
        logic [31:0]          pick;
        logic [31:0]          lowWord;
        logic [31:0]          highWord;
        logic [dataWidth-1:0] msg;
        pick     = $urandom % 10;
        lowWord  = $urandom;
        highWord = $urandom;
        msg      = {highWord, lowWord};
        if (pick < 5) begin
            msg[7:0] = lockOpLock;
        end else if (pick < 9) begin
            msg[7:0] = lockOpUnlock;
        end else if (lowWord[7:0] == lockOpLock || lowWord[7:0] == lockOpUnlock) begin
            msg[7:0] = 8'hff;
        end
        return msg;
    endfunction

    task automatic driveCommand();
        logic [31:0] pick;
        pick = $urandom;
        // A stalled message keeps its contents
        if (!inValid || inReadyS) begin
            if (sent < numMsgs && pick[1:0] != 2'b00) begin
                inValid <= 1'b1;
                inData  <= makeMessage();
                inId    <= pick[7:4];
            end else begin
                inValid <= 1'b0;
            end
        end
    endtask

    task automatic driveOutReady();
        logic [31:0] pick;
        pick = $urandom;
        if (stallLeft > 0) begin
            stallLeft--;
            outReady <= 1'b0;
        end else if (pick[5:0] == 6'd0) begin
            // Long back-pressure stretch
            stallLeft = 10 + int'(pick[10:6]);
            outReady <= 1'b0;
        end else begin
            outReady <= (pick[13:12] != 2'b00);
        end
    endtask

    // Model update for a command taken on this edge
    task automatic acceptCommand();
        lockIdT               id;
        logic [dataWidth-1:0] word;
        id   = inData[8 +: lockIdWidth];
        word = '0;
        sent++;
        case (inData[7:0])
            lockOpLock: begin
                word[0] = !modelHeld[id];
                expData.push_back(word);
                expDest.push_back(inId);
                modelHeld[id] = 1'b1;
            end
            lockOpUnlock: begin
                modelHeld[id] = 1'b0;
            end
            default: begin
            end
        endcase
    endtask

    task automatic consumeReply();
        if (expData.size() == 0) begin
            $display("Error at %0t: reply to 0x%h came with no lock command waiting",
                     $time, outDestS);
            protoErrors++;
        end else begin
            checkGrant(outDataS, expData.pop_front());
            checkDest(outDestS, expDest.pop_front());
            repliesChecked++;
            if (outDataS[0]) begin
                grantsSeen++;
            end
        end
    endtask

    // Beat under back-pressure must not move
    task automatic checkHeldBeat();
        if (outValid !== 1'b1) begin
            $display("Error at %0t: outValid dropped while outReady was low", $time);
            protoErrors++;
        end else begin
            checkGrant(outData, outDataS);
            checkDest(outDest, outDestS);
        end
    endtask

    task automatic sampleOutputs();
        inReadyS  = inReady;
        outValidS = outValid;
        outDataS  = outData;
        outDestS  = outDest;
    endtask

    task automatic printSummary();
        $display("Errors: %0d value, %0d protocol; %0d replies checked, %0d granted",
                 valueErrors, protoErrors, repliesChecked, grantsSeen);
    endtask

    initial begin
        void'($urandom(23965));
        rstN           = 1'b0;
        inData         = '0;
        inValid        = 1'b0;
        inId           = '0;
        outReady       = 1'b0;
        modelHeld      = '0;
        stalledBeat    = 1'b0;
        sent           = 0;
        stallLeft      = 0;
        drained        = 0;
        valueErrors    = 0;
        protoErrors    = 0;
        repliesChecked = 0;
        grantsSeen     = 0;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        if (inReady !== 1'b1 || outValid !== 1'b0) begin
            $display("Error: after reset inReady is not high or outValid is not low");
            protoErrors++;
        end
        sampleOutputs();
        while (sent < numMsgs || expData.size() != 0 || drained < drainCycles) begin
            @(posedge clk);
            if (inValid && inReadyS) begin
                acceptCommand();
            end
            if (outValidS && outReady) begin
                consumeReply();
            end
            stalledBeat = outValidS && !outReady;
            if (sent == numMsgs && expData.size() == 0) begin
                drained++;
            end
            driveCommand();
            driveOutReady();
            @(negedge clk);
            if (stalledBeat) begin
                checkHeldBeat();
            end
            sampleOutputs();
        end
        if (outValid) begin
            $display("Error: a reply is still on the output after the last command");
            protoErrors++;
        end
        printSummary();
        if (valueErrors == 0 && protoErrors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog
    initial begin
        cycleCount = 0;
        while (cycleCount < maxCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: run did not finish within %0d cycles, %0d of %0d commands taken",
                 maxCycles, sent, numMsgs);
        printSummary();
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
rtl/lockPkg.sv
rtl/lockReqIf.sv
rtl/lockAckIf.sv
rtl/lockCmdDecoder.sv
rtl/lockTable.sv
rtl/lockAckSender.sv
rtl/lockUnit.sv
testbench/lockUnitTb.sv

/* Makefile */
# Verilator simulation of the lock unit
# Every variable can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= lockUnitTb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SOURCES   := $(wildcard rtl/*.sv testbench/*.sv)
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "=== PASS ===" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
